//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = pwrCtrlTb
FILELIST  = pwrCtrlTop.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- pwrCtrlTop.f
+incdir+verilog
verilog/pwrCtrlPkg.sv
verilog/pwrReqRegs.sv
verilog/pwrSeqFsm.sv
verilog/pwrSwitchDrv.sv
verilog/pwrCtrlTop.sv
sim/pwrCtrl_assertions.sv
sim/pwrCtrlTb.sv

//--- sim/pwrCtrlTb.sv
// Clear requests are issued only after the previous response was taken, settle writes land before a wake
`timescale 1ns/1ps
`default_nettype none

`include "pwrCtrl_settings.svh"

module pwrCtrlTb
  import pwrCtrlPkg::*;
();

  // Table operations
  typedef enum logic [1:0] {opWrite, opRead, opSleep, opWake} testOp;

  // One table entry, expected read value and settle used for the wake check
  typedef struct packed {
    testOp    op;
    regAddr   addr;
    regData   data;
    regData   expRd;
    settleCnt expSettle;
  } testEntry;

  // Bit positions of the controls inside dom
  localparam int bitPwr2    = 0;
  localparam int bitPwr1    = 1;
  localparam int bitRestore = 2;
  localparam int bitSave    = 3;
  localparam int bitRstn    = 4;
  localparam int bitIso     = 5;
  localparam int bitGate    = 6;

  // Domain controls out of reset
  localparam domainCtrl resetDom = '{gateClk: 1'b0, isolate: 1'b0, rstnNonRet: 1'b1,
                                     saveEdge: 1'b0, restoreEdge: 1'b0,
                                     pwr1On: 1'b1, pwr2On: 1'b1};

  logic      pclk5;
  logic      nprst5;
  logic      reqValid;
  regReq     req;
  logic      reqReady;
  logic      rspValid;
  regRsp     rsp;
  logic      rspReady;
  domainCtrl dom;

  testEntry  tests[$];
  int        seed;
  int        edgeCnt;
  int        cycleLimit;
  int        errors;
  int        checks;
  int        reqCount;
  int        rspCount;
  int        riseAt[7];
  int        fallAt[7];
  int        sleepEdge;
  int        clearEdge;
  domainCtrl prevDom = resetDom;

  pwrCtrlTop uut (
    .pclk5    (pclk5),
    .nprst5   (nprst5),
    .reqValid (reqValid),
    .req      (req),
    .reqReady (reqReady),
    .rspValid (rspValid),
    .rsp      (rsp),
    .rspReady (rspReady),
    .dom      (dom)
  );

  // 100 ns clock
  always #50 pclk5 = ~pclk5;

  // ------------------------------------------------------------
  // Edge counter and watchdog
  // ------------------------------------------------------------
  always @(posedge pclk5)
  begin
    edgeCnt <= edgeCnt + 1;
    if (cycleLimit > 0 && edgeCnt >= cycleLimit)
    begin
      $display("timeout: no result after %0d cycles", edgeCnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // Edge of the latest change of each control, plus handshake counts
  always @(negedge pclk5)
  begin
    for (int b = 0; b < 7; b++)
    begin
      if (dom[b] && !prevDom[b])
        riseAt[b] = edgeCnt;
      if (!dom[b] && prevDom[b])
        fallAt[b] = edgeCnt;
    end
    prevDom = dom;
    // Values stay put until the next rising edge
    if (reqValid && reqReady)
      reqCount++;
    if (rspValid && rspReady)
      rspCount++;
  end

  task automatic checkVal(input string name, input int got, input int exp);
    checks++;
    assert (got == exp)
    else
    begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic void addTest(testOp op, regAddr a, regData d, regData e, settleCnt s);
    tests.push_back('{op: op, addr: a, data: d, expRd: e, expSettle: s});
  endfunction

  // ------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------
  task automatic buildTable();
    // Reset values and register access
    addTest(opRead,  `PWR_ADDR_CTRL,   8'h00, 8'h00, 8'd0);
    addTest(opRead,  `PWR_ADDR_STATUS, 8'h00, 8'h00, 8'd0);
    addTest(opRead,  `PWR_ADDR_SETTLE, 8'h00, 8'd28, 8'd0);
    addTest(opRead,  2'd3,             8'h00, 8'h00, 8'd0);
    addTest(opWrite, 2'd3,             8'h5A, 8'h00, 8'd0);
    addTest(opWrite, `PWR_ADDR_STATUS, 8'hFF, 8'h00, 8'd0);
    addTest(opWrite, `PWR_ADDR_SETTLE, 8'hA5, 8'hA5, 8'd0);
    addTest(opRead,  `PWR_ADDR_SETTLE, 8'h00, 8'hA5, 8'd0);
    // First cycle with the default settle
    addTest(opWrite, `PWR_ADDR_SETTLE, 8'd28, 8'd28, 8'd0);
    addTest(opWrite, `PWR_ADDR_CTRL,   8'h01, 8'h01, 8'd0);
    addTest(opSleep, 2'd0,             8'h00, 8'h00, 8'd0);
    addTest(opRead,  `PWR_ADDR_STATUS, 8'h00, 8'h01, 8'd0);
    addTest(opWrite, `PWR_ADDR_CTRL,   8'h00, 8'h00, 8'd0);
    addTest(opWake,  2'd0,             8'h00, 8'h00, 8'd28);
    addTest(opRead,  `PWR_ADDR_STATUS, 8'h00, 8'h00, 8'd0);
    // Second cycle, short settle
    addTest(opWrite, `PWR_ADDR_SETTLE, 8'd5,  8'd5,  8'd0);
    addTest(opWrite, `PWR_ADDR_CTRL,   8'h01, 8'h01, 8'd0);
    addTest(opSleep, 2'd0,             8'h00, 8'h00, 8'd0);
    addTest(opRead,  `PWR_ADDR_STATUS, 8'h00, 8'h01, 8'd0);
    addTest(opWrite, `PWR_ADDR_CTRL,   8'h00, 8'h00, 8'd0);
    addTest(opWake,  2'd0,             8'h00, 8'h00, 8'd5);
    addTest(opRead,  `PWR_ADDR_STATUS, 8'h00, 8'h00, 8'd0);
    // Clear lands during power-down
    addTest(opWrite, `PWR_ADDR_CTRL,   8'h01, 8'h01, 8'd0);
    addTest(opWrite, `PWR_ADDR_CTRL,   8'h00, 8'h00, 8'd0);
    addTest(opSleep, 2'd0,             8'h00, 8'h00, 8'd0);
    addTest(opWake,  2'd0,             8'h00, 8'h00, 8'd5);
    addTest(opRead,  `PWR_ADDR_STATUS, 8'h00, 8'h00, 8'd0);
    addTest(opRead,  `PWR_ADDR_CTRL,   8'h00, 8'h00, 8'd0);
  endtask

  // Rough cycle budget per entry
  function automatic int sumLengths();
    int total;
    total = 0;
    foreach (tests[i])
    begin
      case (tests[i].op)
        opSleep: total += 8;
        opWake:  total += int'(tests[i].expSettle) + 12;
        default: total += 6;
      endcase
    end
    return total;
  endfunction

  // Called on a rising edge, returns on the edge that takes the response
  task automatic doRequest(input logic isWrite, input regAddr address, input regData wrData,
                           output regData rdata, output int acceptEdge);
    int     holdCycles;
    logic   accepted;
    regData held;
    holdCycles = int'($unsigned($random(seed)) % 4);
    reqValid <= 1'b1;
    req      <= '{write: isWrite, addr: address, wdata: wrData};
    do
    begin
      @(negedge pclk5);
      accepted = reqReady;
      @(posedge pclk5);
    end while (!accepted);
    reqValid <= 1'b0;
    if (holdCycles == 0)
      rspReady <= 1'b1;
    @(negedge pclk5);
    acceptEdge = edgeCnt;
    checkVal("rspValid", int'(rspValid), 1);
    checkVal("reqReady", int'(reqReady), 0);
    held = rsp.rdata;
    // Back-pressure, response must hold still
    for (int i = 0; i < holdCycles; i++)
    begin
      @(posedge pclk5);
      if (i == holdCycles - 1)
        rspReady <= 1'b1;
      @(negedge pclk5);
      checkVal("rsp.rdata held", int'(rsp.rdata), int'(held));
      checkVal("rspValid held", int'(rspValid), 1);
      checkVal("reqReady held", int'(reqReady), 0);
    end
    @(posedge pclk5);
    rspReady <= 1'b0;
    rdata = held;
  endtask

  // Offsets from the accepting edge of the set request
  task automatic checkSleep();
    checkVal("gateClk rise edge", riseAt[bitGate], sleepEdge + 1);
    checkVal("isolate rise edge", riseAt[bitIso], sleepEdge + 3);
    checkVal("saveEdge rise edge", riseAt[bitSave], sleepEdge + 4);
    checkVal("saveEdge fall edge", fallAt[bitSave], sleepEdge + 5);
    checkVal("rstnNonRet fall edge", fallAt[bitRstn], sleepEdge + 6);
    checkVal("pwr1On fall edge", fallAt[bitPwr1], sleepEdge + 6);
    checkVal("pwr2On fall edge", fallAt[bitPwr2], sleepEdge + 6);
  endtask

  // Wake starts at the clear or at power-off, whichever is later
  task automatic checkWake(input int settleVal);
    int base;
    int restEdge;
    base     = (clearEdge > fallAt[bitPwr1]) ? clearEdge : fallAt[bitPwr1];
    restEdge = riseAt[bitRestore];
    checkVal("pwr1On rise edge", riseAt[bitPwr1], base + 1);
    checkVal("pwr2On rise edge", riseAt[bitPwr2], riseAt[bitPwr1] + 1);
    checkVal("restoreEdge rise edge", restEdge, riseAt[bitPwr2] + settleVal + 1);
    checkVal("restoreEdge fall edge", fallAt[bitRestore], restEdge + 1);
    checkVal("isolate fall edge", fallAt[bitIso], restEdge + 2);
    checkVal("gateClk fall edge", fallAt[bitGate], restEdge + 3);
    checkVal("rstnNonRet rise edge", riseAt[bitRstn], restEdge + 5);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial
  begin
    testEntry entry;
    regData   rdata;
    int       acc;
    int       errBefore;
    pclk5    = 1'b0;
    nprst5   = 1'b0;
    reqValid = 1'b0;
    req      = '0;
    rspReady = 1'b0;
    seed     = 15;
    buildTable();
    cycleLimit = 2 * sumLengths() + 16 + 64;
    repeat (16) @(posedge pclk5);
    nprst5 <= 1'b1;
    @(negedge pclk5);
    checkVal("dom", int'(dom), int'(resetDom));
    checkVal("reqReady", int'(reqReady), 1);
    checkVal("rspValid", int'(rspValid), 0);
    $display("test reset: %s", (errors == 0) ? "ok" : "mismatch");
    @(posedge pclk5);
    for (int t = 0; t < tests.size(); t++)
    begin
      entry     = tests[t];
      errBefore = errors;
      case (entry.op)
        opSleep:
        begin
          // Switches drop after the latest set, even if the clear already came in
          do
          begin
            @(posedge pclk5);
          end while (fallAt[bitPwr2] <= sleepEdge);
          checkSleep();
        end
        opWake:
        begin
          do
          begin
            @(negedge pclk5);
          end while (!dom.rstnNonRet);
          @(posedge pclk5);
          checkWake(int'(entry.expSettle));
        end
        default:
        begin
          doRequest(entry.op == opWrite, entry.addr, entry.data, rdata, acc);
          checkVal("rsp.rdata", int'(rdata), int'(entry.expRd));
          // Remember where each CTRL change was accepted
          if (entry.op == opWrite && entry.addr == `PWR_ADDR_CTRL)
          begin
            if (entry.data[0])
              sleepEdge = acc;
            else
              clearEdge = acc;
          end
        end
      endcase
      $display("test %0d %s: %s", t, entry.op.name(), (errors == errBefore) ? "ok" : "mismatch");
    end
    // One response per accepted request
    assert (reqCount == rspCount)
    else
    begin
      $display("%0d requests were accepted but %0d responses were taken", reqCount, rspCount);
      errors++;
    end
    assert (uut.chk.failCount == 0)
    else
    begin
      $display("the bound ordering checker fired %0d times", uut.chk.failCount);
      errors++;
    end
    $display("%0d tests, %0d checks, %0d errors", tests.size() + 1, checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/pwrCtrl_assertions.sv
// Checks the ordering of the domain controls only, and stays quiet while nprst5 is low
`timescale 1ns/1ps
`default_nettype none

module pwrCtrl_assertions
  import pwrCtrlPkg::*;
(
  input logic      pclk5,
  input logic      nprst5,
  input domainCtrl dom,
  input logic      setStatus,
  input logic      clrStatus
);

  // Failure counts, one per property
  int overlapErr;
  int isoErr;
  int offErr;
  int upErr;
  int failCount;

  assign failCount = overlapErr + isoErr + offErr + upErr;

  // ------------------------------------------------------------
  // Ordering rules
  // ------------------------------------------------------------

  // Status strobes are exclusive
  noStrobeOverlap: assert property (@(posedge pclk5) disable iff (!nprst5)
    !(setStatus && clrStatus))
  else
  begin
    $error("status set and clear strobes high together");
    overlapErr++;
  end

  // Clock gated before isolation
  isoAfterGate: assert property (@(posedge pclk5) disable iff (!nprst5)
    $rose(dom.isolate) |-> dom.gateClk)
  else
  begin
    $error("isolate rose while the clock was running");
    isoErr++;
  end

  // Both switches drop together, only behind isolation
  pwrOffOrder: assert property (@(posedge pclk5) disable iff (!nprst5)
    $fell(dom.pwr1On) |-> (dom.isolate && $fell(dom.pwr2On)))
  else
  begin
    $error("power switches fell out of order or without isolation");
    offErr++;
  end

  // In-rush stagger
  pwrUpStagger: assert property (@(posedge pclk5) disable iff (!nprst5)
    $rose(dom.pwr1On) |=> $rose(dom.pwr2On))
  else
  begin
    $error("pwr2On did not follow pwr1On by one cycle");
    upErr++;
  end

endmodule

bind pwrCtrlTop pwrCtrl_assertions chk (
  .pclk5     (pclk5),
  .nprst5    (nprst5),
  .dom       (dom),
  .setStatus (setStatus),
  .clrStatus (clrStatus)
);

`default_nettype wire

//--- verilog/pwrCtrlPkg.sv
// Types for a single switchable domain. Widths come from pwrCtrl_settings.svh
`default_nettype none

package pwrCtrlPkg;

  `include "pwrCtrl_settings.svh"

  // Register port vectors
  typedef logic [`PWR_DATA_W-1:0] regData;
  typedef logic [`PWR_ADDR_W-1:0] regAddr;

  // Settling wait, loaded into the switch driver counter
  typedef logic [`PWR_SETTLE_W-1:0] settleCnt;

  // Request channel payload
  typedef struct packed {
    logic   write;
    regAddr addr;
    regData wdata;
  } regReq;

  // Response channel payload
  // Writes return the new register value
  typedef struct packed {
    regData rdata;
  } regRsp;

  // Controls for the switchable domain
  typedef struct packed {
    logic gateClk;
    logic isolate;
    logic rstnNonRet;
    logic saveEdge;
    logic restoreEdge;
    logic pwr1On;
    logic pwr2On;
  } domainCtrl;

  // Power-shutoff sequencer states
  typedef enum logic [3:0] {
    Idle, ClkOff, WaitGate, Isolate, SaveEdge, PrePwrOff, PwrOff,
    PwrUp, RestoreEdge, WaitRestore, DeIsolate, ClkOn, WaitClk, RstClear
  } seqState;

endpackage

`default_nettype wire

//--- verilog/pwrCtrlTop.sv
// One switchable domain. pwr1On and pwr2On in dom come from the switch driver
`timescale 1ns/1ps
`default_nettype none

module pwrCtrlTop
  import pwrCtrlPkg::*;
(
  input  logic      pclk5,
  input  logic      nprst5,
  input  logic      reqValid,
  input  regReq     req,
  output logic      reqReady,
  output logic      rspValid,
  output regRsp     rsp,
  input  logic      rspReady,
  output domainCtrl dom
);

  // ------------------------------------------------------------
  // Internal connections
  // ------------------------------------------------------------
  logic      l1Req;
  logic      setStatus;
  logic      clrStatus;
  logic      powerDown;
  logic      powerGood;
  logic      pwr1On;
  logic      pwr2On;
  settleCnt  settle;
  domainCtrl seqCtrl;

  // Software register port
  pwrReqRegs regs (
    .pclk5     (pclk5),
    .nprst5    (nprst5),
    .reqValid  (reqValid),
    .req       (req),
    .reqReady  (reqReady),
    .rspValid  (rspValid),
    .rsp       (rsp),
    .rspReady  (rspReady),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .l1Req     (l1Req),
    .settle    (settle)
  );

  // Power-shutoff sequencer
  pwrSeqFsm seq (
    .pclk5     (pclk5),
    .nprst5    (nprst5),
    .l1Req     (l1Req),
    .powerGood (powerGood),
    .powerDown (powerDown),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .ctrl      (seqCtrl)
  );

  // Power switch staggering and settle wait
  pwrSwitchDrv sw (
    .pclk5     (pclk5),
    .nprst5    (nprst5),
    .powerDown (powerDown),
    .settle    (settle),
    .pwr1On    (pwr1On),
    .pwr2On    (pwr2On),
    .powerGood (powerGood)
  );

  // Sequencer controls with the real switch enables
  assign dom = '{gateClk:     seqCtrl.gateClk,
                 isolate:     seqCtrl.isolate,
                 rstnNonRet:  seqCtrl.rstnNonRet,
                 saveEdge:    seqCtrl.saveEdge,
                 restoreEdge: seqCtrl.restoreEdge,
                 pwr1On:      pwr1On,
                 pwr2On:      pwr2On};

endmodule

`default_nettype wire

//--- verilog/pwrCtrl_settings.svh
// One power domain only. Address 3 is reserved and the settle count replaces power-good sensing
`ifndef PWRCTRL_SETTINGS_SVH
`define PWRCTRL_SETTINGS_SVH

// ------------------------------------------------------------
// Register port widths
// ------------------------------------------------------------

// Register data width
`define PWR_DATA_W 8

// Register address width
`define PWR_ADDR_W 2

// ------------------------------------------------------------
// Register map
// ------------------------------------------------------------

// Control register, bit 0 requests low power
`define PWR_ADDR_CTRL 2'd0
// Status register, bit 0 set during a low-power cycle
`define PWR_ADDR_STATUS 2'd1
// Settle wait in cycles after the second switch turns on
`define PWR_ADDR_SETTLE 2'd2

// Settle register reset value and counter width
`define PWR_SETTLE_DEFAULT 8'd28
`define PWR_SETTLE_W `PWR_DATA_W

`endif

//--- verilog/pwrReqRegs.sv
// One request in flight. Address 3 reads zero, STATUS ignores writes, only CTRL bit 0 is stored
`timescale 1ns/1ps
`default_nettype none

`include "pwrCtrl_settings.svh"

module pwrReqRegs
  import pwrCtrlPkg::*;
(
  input  logic     pclk5,
  input  logic     nprst5,
  input  logic     reqValid,
  input  regReq    req,
  output logic     reqReady,
  output logic     rspValid,
  output regRsp    rsp,
  input  logic     rspReady,
  input  logic     setStatus,
  input  logic     clrStatus,
  output logic     l1Req,
  output settleCnt settle
);

  logic     accept;
  logic     ctrlBit;
  logic     ctrlNext;
  logic     statusBit;
  logic     statusNext;
  settleCnt settleReg;
  settleCnt settleNext;
  regData   rdNext;

  // Back-pressure, no new request while a response waits
  assign reqReady = ~rspValid;
  assign accept   = reqValid & reqReady;

  // ------------------------------------------------------------
  // Next register values
  // ------------------------------------------------------------
  always_comb
  begin
    ctrlNext   = ctrlBit;
    settleNext = settleReg;
    if (accept && req.write)
    begin
      case (req.addr)
        `PWR_ADDR_CTRL:   ctrlNext = req.wdata[0];
        `PWR_ADDR_SETTLE: settleNext = req.wdata;
        default:          ;
      endcase
    end
  end

  // Clear wins, the strobes never overlap anyway
  always_comb
  begin
    if (clrStatus)
      statusNext = 1'b0;
    else if (setStatus)
      statusNext = 1'b1;
    else
      statusNext = statusBit;
  end

  // Read data taken from next values so a write returns what it wrote
  always_comb
  begin
    case (req.addr)
      `PWR_ADDR_CTRL:   rdNext = {{(`PWR_DATA_W-1){1'b0}}, ctrlNext};
      `PWR_ADDR_STATUS: rdNext = {{(`PWR_DATA_W-1){1'b0}}, statusNext};
      `PWR_ADDR_SETTLE: rdNext = settleNext;
      default:          rdNext = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Registers and response handshake
  // ------------------------------------------------------------
  always_ff @(posedge pclk5 or negedge nprst5)
  begin
    if (!nprst5)
    begin
      ctrlBit   <= 1'b0;
      statusBit <= 1'b0;
      settleReg <= `PWR_SETTLE_DEFAULT;
      rspValid  <= 1'b0;
    end
    else
    begin
      ctrlBit   <= ctrlNext;
      statusBit <= statusNext;
      settleReg <= settleNext;
      // Valid holds until the response is taken
      if (accept)
        rspValid <= 1'b1;
      else if (rspReady)
        rspValid <= 1'b0;
    end
  end

  // Response payload, stable while held
  always_ff @(posedge pclk5)
  begin
    if (accept)
      rsp <= '{rdata: rdNext};
  end

  assign l1Req  = ctrlBit;
  assign settle = settleReg;

endmodule

`default_nettype wire

//--- verilog/pwrSeqFsm.sv
// Waits only in Idle, PwrOff and PwrUp. A cleared request is only acted on once PwrOff is reached
`timescale 1ns/1ps
`default_nettype none

module pwrSeqFsm
  import pwrCtrlPkg::*;
(
  input  logic      pclk5,
  input  logic      nprst5,
  input  logic      l1Req,
  input  logic      powerGood,
  output logic      powerDown,
  output logic      setStatus,
  output logic      clrStatus,
  output domainCtrl ctrl
);

  seqState state;
  seqState nextState;

  // Registered domain controls
  logic gateClkQ;
  logic isolateQ;
  logic rstnNonRetQ;
  logic saveEdgeQ;
  logic restoreEdgeQ;

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb
  begin
    nextState = state;
    case (state)
      // Start power-down once software asks for it
      Idle:
        if (l1Req)
          nextState = ClkOff;
      ClkOff:
        nextState = WaitGate;
      // One cycle for the clock gate to settle
      WaitGate:
        nextState = Isolate;
      Isolate:
        nextState = SaveEdge;
      SaveEdge:
        nextState = PrePwrOff;
      PrePwrOff:
        nextState = PwrOff;
      // Stay off until the request bit is cleared
      PwrOff:
        if (!l1Req)
          nextState = PwrUp;
      // Switch driver staggers the switches and counts settle
      PwrUp:
        if (powerGood)
          nextState = RestoreEdge;
      RestoreEdge:
        nextState = WaitRestore;
      WaitRestore:
        nextState = DeIsolate;
      DeIsolate:
        nextState = ClkOn;
      // Clock runs a cycle before reset is released
      ClkOn:
        nextState = WaitClk;
      WaitClk:
        nextState = RstClear;
      RstClear:
        nextState = Idle;
      default:
        nextState = Idle;
    endcase
  end

  always_ff @(posedge pclk5 or negedge nprst5)
  begin
    if (!nprst5)
      state <= Idle;
    else
      state <= nextState;
  end

  // ------------------------------------------------------------
  // Domain controls, registered from next state
  // ------------------------------------------------------------
  always_ff @(posedge pclk5 or negedge nprst5)
  begin
    if (!nprst5)
    begin
      gateClkQ     <= 1'b0;
      isolateQ     <= 1'b0;
      rstnNonRetQ  <= 1'b1;
      saveEdgeQ    <= 1'b0;
      restoreEdgeQ <= 1'b0;
    end
    else
    begin
      // Clock stays gated from ClkOff until ClkOn
      gateClkQ    <= !(nextState inside {Idle, ClkOn, WaitClk, RstClear});
      isolateQ    <= nextState inside {Isolate, SaveEdge, PrePwrOff, PwrOff,
                                       PwrUp, RestoreEdge, WaitRestore};
      // Non-retention flops held in reset from power-off to RstClear
      rstnNonRetQ <= !(nextState inside {PwrOff, PwrUp, RestoreEdge, WaitRestore,
                                         DeIsolate, ClkOn, WaitClk});
      // Single-cycle retention pulses
      saveEdgeQ    <= (nextState == SaveEdge);
      restoreEdgeQ <= (nextState == RestoreEdge);
    end
  end

  // Switch driver follows this level
  assign powerDown = (nextState == PwrOff);

  // Status strobes
  assign setStatus = (state == Idle) && (nextState == ClkOff);
  assign clrStatus = (state == RstClear);

  // Switch enables come from the switch driver at the top level
  assign ctrl = '{gateClk:     gateClkQ,
                  isolate:     isolateQ,
                  rstnNonRet:  rstnNonRetQ,
                  saveEdge:    saveEdgeQ,
                  restoreEdge: restoreEdgeQ,
                  pwr1On:      1'b1,
                  pwr2On:      1'b1};

endmodule

`default_nettype wire

//--- verilog/pwrSwitchDrv.sv
// Settle is sampled when pwr2On rises, later writes apply to the next wake only
`timescale 1ns/1ps
`default_nettype none

module pwrSwitchDrv
  import pwrCtrlPkg::*;
(
  input  logic     pclk5,
  input  logic     nprst5,
  input  logic     powerDown,
  input  settleCnt settle,
  output logic     pwr1On,
  output logic     pwr2On,
  output logic     powerGood
);

  settleCnt cnt;
  logic     settling;
  logic     pwr2Rise;

  // Both switches off together, second one back a cycle after the first
  always_ff @(posedge pclk5 or negedge nprst5)
  begin
    if (!nprst5)
    begin
      pwr1On <= 1'b1;
      pwr2On <= 1'b1;
    end
    else
    begin
      pwr1On <= ~powerDown;
      pwr2On <= pwr1On & ~powerDown;
    end
  end

  // Edge on which pwr2On turns on
  assign pwr2Rise = pwr1On & ~pwr2On & ~powerDown;

  // Settle countdown, stands in for analog power-good
  always_ff @(posedge pclk5 or negedge nprst5)
  begin
    if (!nprst5)
    begin
      settling <= 1'b0;
      cnt      <= '0;
    end
    else if (powerDown)
      settling <= 1'b0;
    else if (pwr2Rise)
    begin
      settling <= 1'b1;
      cnt      <= settle;
    end
    else if (settling)
    begin
      if (cnt == '0)
        settling <= 1'b0;
      else
        cnt <= cnt - settleCnt'(1);
    end
  end

  // One-cycle strobe, settle cycles after pwr2On rises
  assign powerGood = settling & (cnt == '0);

endmodule

`default_nettype wire
